// ==== bridgeFifo/bridgeFifo.sv ====
/*
 * Bridge FIFO
 * Directional word FIFO between CPU data and PCI AD, with fill level,
 * flush and a sticky overflow flag
 */
`timescale 1ns/1ps

module bridgeFifo (
    input  logic                             BCLK,
    input  logic                             nRESET,
    input  logic                             pciDir,
    input  logic                             cpuPush,
    input  logic                             cpuPop,
    input  logic                             pciPush,
    input  logic                             pciPop,
    input  logic [bridgePkg::dataWidth-1:0]  dIn,
    input  logic [bridgePkg::dataWidth-1:0]  adIn,
    input  bridgePkg::ctrlReg_t              ctrl,
    output logic [bridgePkg::dataWidth-1:0]  head,
    output logic [bridgePkg::levelWidth-1:0] level,
    output logic                             full,
    output logic                             empty,
    output logic                             overflow
);
    import bridgePkg::*;

    logic [dataWidth-1:0]  mem [fifoDepth];
    logic [ptrWidth-1:0]   wrPtr;
    logic [ptrWidth-1:0]   rdPtr;
    logic [levelWidth-1:0] count;
    logic [dataWidth-1:0]  pushData;
    logic                  pushReq;
    logic                  popReq;
    logic                  pushOk;
    logic                  popOk;

    ////////////////////////////////////////////////////////////////////////////
    // Side select
    ////////////////////////////////////////////////////////////////////////////

    // pciDir high, CPU fills and PCI drains
    assign pushReq  = pciDir ? cpuPush : pciPush;
    assign popReq   = pciDir ? pciPop : cpuPop;
    assign pushData = pciDir ? dIn : adIn;

    assign popOk  = popReq && !empty;
    // A pop in the same cycle makes room for the push
    assign pushOk = pushReq && (!full || popOk);

    // Storage
    always_ff @(posedge BCLK) begin
        if (pushOk) begin
            mem[wrPtr] <= pushData;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Pointers and level
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge BCLK or negedge nRESET) begin
        if (!nRESET) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else if (ctrl.flush) begin
            // Flush wins over any beat in the same cycle
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (pushOk) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (popOk) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({pushOk, popOk})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // PCI side cannot stall, so a push into a full FIFO is lost
    always_ff @(posedge BCLK or negedge nRESET) begin
        if (!nRESET) begin
            overflow <= 1'b0;
        end else if (pushReq && full && !popOk) begin
            overflow <= 1'b1;
        end else if (ctrl.clearOverflow) begin
            overflow <= 1'b0;
        end
    end

    assign head  = mem[rdPtr];
    assign level = count;
    assign full  = (count == levelWidth'(fifoDepth));
    assign empty = (count == '0);

    // Neither side pops while the FIFO is empty
    aNoEmptyPop: assert property (@(posedge BCLK) disable iff (!nRESET)
        popReq |-> !empty);

endmodule

// ==== common/bridgePkg.sv ====
/*
 * Bridge package
 * Data path sizes, CPU and PCI bus bundles and the bridge register word
 * shared by the acknowledge generator, FIFO, PCI port and register block
 */
package bridgePkg;

    ////////////////////////////////////////////////////////////////////////////
    // Data path sizes
    ////////////////////////////////////////////////////////////////////////////

    localparam int dataWidth  = 32;
    localparam int fifoDepth  = 8;
    // Holds 0 to fifoDepth inclusive
    localparam int levelWidth = 4;
    localparam int burstBeats = 4;
    localparam int ptrWidth   = $clog2(fifoDepth);
    localparam int beatWidth  = $clog2(burstBeats);
    // Bridge register slot on address bits 28 to 2
    localparam int regAddr    = 1;

    ////////////////////////////////////////////////////////////////////////////
    // Bus bundles
    ////////////////////////////////////////////////////////////////////////////

    // MC68040 side, burst is tt0 high with tt1 low
    typedef struct packed {
        logic [31:2] addr;
        logic        rnw;
        logic        tt0;
        logic        tt1;
        logic        nTs;
        logic        nBg;
        logic        nBen;
    } cpuBus_t;

    // PCI side strobes, sampled on BCLK
    typedef struct packed {
        logic pciCycle;
        logic nIrdy;
        logic nTrdy;
    } pciBus_t;

    ////////////////////////////////////////////////////////////////////////////
    // Bridge register word
    ////////////////////////////////////////////////////////////////////////////

    // Write view, flush in bit 0
    typedef struct packed {
        logic [28:0] reserved;
        logic        clearOverflow;
        logic        burstEnable;
        logic        flush;
    } ctrlReg_t;

    // Read view, level in bits 3 to 0
    typedef struct packed {
        logic [24:0]           reserved;
        logic                  empty;
        logic                  pciDir;
        logic                  overflow;
        logic [levelWidth-1:0] level;
    } statReg_t;

    typedef union packed {
        ctrlReg_t ctrl;
        statReg_t stat;
    } regWord_u;

    // Bursts allowed out of reset
    localparam ctrlReg_t ctrlReset = '{
        reserved:      '0,
        clearOverflow: 1'b0,
        burstEnable:   1'b1,
        flush:         1'b0
    };

endpackage

// ==== hdl/bridgeRegs.sv ====
/*
 * Bridge registers
 * Control word written by register cycles and status readback,
 * both views of one register word
 */
`timescale 1ns/1ps

module bridgeRegs (
    input  logic                             BCLK,
    input  logic                             nRESET,
    input  logic                             regWr,
    input  logic                             regRd,
    input  logic [bridgePkg::dataWidth-1:0]  dIn,
    input  logic [bridgePkg::levelWidth-1:0] level,
    input  logic                             overflow,
    input  logic                             empty,
    input  logic                             pciDir,
    input  logic [bridgePkg::dataWidth-1:0]  head,
    output bridgePkg::ctrlReg_t              ctrl,
    output logic [bridgePkg::dataWidth-1:0]  dOut
);
    import bridgePkg::*;

    regWord_u wrWord;
    regWord_u rdWord;

    // CPU write data seen as control
    assign wrWord = dIn;

    ////////////////////////////////////////////////////////////////////////////
    // Control register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge BCLK or negedge nRESET) begin
        if (!nRESET) begin
            ctrl <= ctrlReset;
        end else if (regWr) begin
            ctrl.flush         <= wrWord.ctrl.flush;
            ctrl.burstEnable   <= wrWord.ctrl.burstEnable;
            ctrl.clearOverflow <= wrWord.ctrl.clearOverflow;
        end else begin
            // Command bits are pulses, burstEnable is a level
            ctrl.flush         <= 1'b0;
            ctrl.clearOverflow <= 1'b0;
        end
    end

    // Status view of the same word
    always_comb begin
        rdWord.stat.reserved = '0;
        rdWord.stat.empty    = empty;
        rdWord.stat.pciDir   = pciDir;
        rdWord.stat.overflow = overflow;
        rdWord.stat.level    = level;
    end

    // Register read returns status, data reads return the FIFO head
    assign dOut = regRd ? rdWord : head;

    // Register cycles are single beat with a trailing cycle, so flush is one pulse
    aFlushPulse: assert property (@(posedge BCLK) disable iff (!nRESET)
        ctrl.flush |=> !ctrl.flush);

endmodule

// ==== hdl/busBridge.sv ====
/*
 * Bus bridge top
 * PCI host bridge data path for an MC68040 class CPU
 */
`timescale 1ns/1ps

module busBridge (
    input  logic                            BCLK,
    input  logic                            nRESET,
    input  bridgePkg::cpuBus_t              cpu,
    input  logic [bridgePkg::dataWidth-1:0] dIn,
    output logic [bridgePkg::dataWidth-1:0] dOut,
    output logic                            dOe,
    output logic                            nTA,
    output logic                            taOe,
    input  bridgePkg::pciBus_t              pci,
    input  logic [bridgePkg::dataWidth-1:0] adIn,
    output logic [bridgePkg::dataWidth-1:0] adOut,
    output logic                            adOe
);
    import bridgePkg::*;

    ctrlReg_t              ctrl;
    logic [dataWidth-1:0]  head;
    logic [levelWidth-1:0] level;
    logic                  regCycle;
    logic                  cpuPush;
    logic                  cpuPop;
    logic                  regWr;
    logic                  regRd;
    logic                  pciDir;
    logic                  pciPush;
    logic                  pciPop;
    logic                  full;
    logic                  empty;
    logic                  overflow;

    // Bridge register slot selected with nBen
    assign regCycle = !cpu.nBen && (cpu.addr[28:2] == 27'(regAddr));

    ////////////////////////////////////////////////////////////////////////////
    // CPU side
    ////////////////////////////////////////////////////////////////////////////

    taGenerator uTaGenerator (
        .BCLK, .nRESET, .cpu, .regCycle, .ctrl, .full, .empty,
        .nTA, .taOe, .cpuPush, .cpuPop, .regWr, .regRd, .dOe
    );

    bridgeRegs uBridgeRegs (
        .BCLK, .nRESET, .regWr, .regRd, .dIn,
        .level, .overflow, .empty, .pciDir, .head, .ctrl, .dOut
    );

    // Shared FIFO, steered by pciDir
    bridgeFifo uBridgeFifo (
        .BCLK, .nRESET, .pciDir, .cpuPush, .cpuPop, .pciPush, .pciPop,
        .dIn, .adIn, .ctrl, .head, .level, .full, .empty, .overflow
    );

    // PCI side
    pciDataPort uPciDataPort (
        .BCLK, .nRESET, .pci, .cpu, .head,
        .pciDir, .pciPush, .pciPop, .adOut, .adOe
    );

endmodule

// ==== hdl/pciDataPort.sv ====
/*
 * PCI data port
 * Latches bus direction at the start of each PCI cycle, turns PCI beats
 * into FIFO strobes and drives AD from the FIFO head
 */
`timescale 1ns/1ps

module pciDataPort (
    input  logic                            BCLK,
    input  logic                            nRESET,
    input  bridgePkg::pciBus_t              pci,
    input  bridgePkg::cpuBus_t              cpu,
    input  logic [bridgePkg::dataWidth-1:0] head,
    output logic                            pciDir,
    output logic                            pciPush,
    output logic                            pciPop,
    output logic [bridgePkg::dataWidth-1:0] adOut,
    output logic                            adOe
);

    logic cycleLast;
    logic cycleRise;
    logic dirReg;
    logic dirSel;
    logic pciBeat;

    ////////////////////////////////////////////////////////////////////////////
    // Direction latch
    ////////////////////////////////////////////////////////////////////////////

    // First BCLK sample with pciCycle high
    assign cycleRise = pci.pciCycle && !cycleLast;

    // CPU writing with the bus granted, or a PCI master reading the CPU side
    // Both mean data flows CPU to PCI
    assign dirSel = (!cpu.nBg && !cpu.rnw) || (cpu.nBg && cpu.rnw);

    always_ff @(posedge BCLK or negedge nRESET) begin
        if (!nRESET) begin
            cycleLast <= 1'b0;
            // Out of reset the bridge points CPU to PCI
            dirReg    <= 1'b1;
        end else begin
            cycleLast <= pci.pciCycle;
            if (cycleRise) begin
                dirReg <= dirSel;
            end
        end
    end

    // New direction is used already in the opening cycle
    assign pciDir = cycleRise ? dirSel : dirReg;

    ////////////////////////////////////////////////////////////////////////////
    // Beat detect and AD drive
    ////////////////////////////////////////////////////////////////////////////

    // Both ready strobes low inside a PCI cycle
    assign pciBeat = pci.pciCycle && !pci.nIrdy && !pci.nTrdy;

    // Beat fills the FIFO toward the CPU, or drains it toward PCI
    assign pciPush = pciBeat && !pciDir;
    assign pciPop  = pciBeat && pciDir;

    // AD always shows the head word, enable decides who sees it
    assign adOut = head;
    assign adOe  = pci.pciCycle && pciDir;

endmodule

// ==== tb.f ====
+incdir+test
common/bridgePkg.sv
transferAck/taGenerator.sv
bridgeFifo/bridgeFifo.sv
hdl/pciDataPort.sv
hdl/bridgeRegs.sv
hdl/busBridge.sv
test/busBridgeTb.sv

// ==== test/bridgeStim.svh ====
/*
 * Bridge stimulus table
 * Bus operations in run order, with the status a register read returns
 */
`ifndef BRIDGE_STIM_SVH
`define BRIDGE_STIM_SVH

typedef enum logic [2:0] {
    cpuWrite,
    cpuRead,
    pciWrite,
    pciRead,
    regWrite,
    regRead
} stimOp_t;

typedef struct packed {
    stimOp_t    op;
    logic       burst;
    logic [3:0] beats;
    // Control bits clearOverflow, burstEnable, flush
    logic [2:0] ctrlVal;
    logic [3:0] expLevel;
    logic       expOverflow;
    logic       expDir;
} stimEntry_t;

localparam int numSteps = 22;

// Columns: op, burst, beats, control, level, overflow, pciDir
stimEntry_t stimTable [numSteps] = '{
    '{regRead,  1'b0, 4'd1, 3'b000, 4'd0, 1'b0, 1'b1},
    '{cpuWrite, 1'b1, 4'd4, 3'b000, 4'd0, 1'b0, 1'b0},
    '{pciRead,  1'b0, 4'd4, 3'b000, 4'd0, 1'b0, 1'b0},
    '{regRead,  1'b0, 4'd1, 3'b000, 4'd0, 1'b0, 1'b1},
    '{pciWrite, 1'b0, 4'd3, 3'b000, 4'd0, 1'b0, 1'b0},
    '{regRead,  1'b0, 4'd1, 3'b000, 4'd3, 1'b0, 1'b0},
    // Fourth beat waits for a PCI push
    '{cpuRead,  1'b1, 4'd4, 3'b000, 4'd0, 1'b0, 1'b0},
    '{regRead,  1'b0, 4'd1, 3'b000, 4'd0, 1'b0, 1'b0},
    // Direction back to CPU to PCI, no data
    '{pciRead,  1'b0, 4'd0, 3'b000, 4'd0, 1'b0, 1'b0},
    '{cpuWrite, 1'b1, 4'd4, 3'b000, 4'd0, 1'b0, 1'b0},
    '{cpuWrite, 1'b1, 4'd4, 3'b000, 4'd0, 1'b0, 1'b0},
    '{regRead,  1'b0, 4'd1, 3'b000, 4'd8, 1'b0, 1'b1},
    // Full FIFO, beat waits for a PCI pop
    '{cpuWrite, 1'b0, 4'd1, 3'b000, 4'd0, 1'b0, 1'b0},
    '{pciWrite, 1'b0, 4'd1, 3'b000, 4'd0, 1'b0, 1'b0},
    '{regRead,  1'b0, 4'd1, 3'b000, 4'd8, 1'b1, 1'b0},
    '{regWrite, 1'b0, 4'd1, 3'b110, 4'd0, 1'b0, 1'b0},
    '{regRead,  1'b0, 4'd1, 3'b000, 4'd8, 1'b0, 1'b0},
    // Bursts off, then a burst cycle ends after one beat
    '{regWrite, 1'b0, 4'd1, 3'b000, 4'd0, 1'b0, 1'b0},
    '{cpuRead,  1'b1, 4'd1, 3'b000, 4'd0, 1'b0, 1'b0},
    '{regRead,  1'b0, 4'd1, 3'b000, 4'd7, 1'b0, 1'b0},
    '{regWrite, 1'b0, 4'd1, 3'b001, 4'd0, 1'b0, 1'b0},
    '{regRead,  1'b0, 4'd1, 3'b000, 4'd0, 1'b0, 1'b0}
};

`endif

// ==== test/busBridgeTb.sv ====
/*
 * Bus bridge testbench
 * Runs CPU, PCI and register cycles from a stimulus table and checks
 * the bridge against a queue model of its FIFO
 */
`timescale 1ns/1ps

module busBridgeTb;
    import bridgePkg::*;

    // Stalled cycles before the opposite side is served
    localparam int stallHold = 3;

    logic                 BCLK;
    logic                 nRESET;
    cpuBus_t              cpu;
    logic [dataWidth-1:0] dIn;
    logic [dataWidth-1:0] dOut;
    logic                 dOe;
    logic                 nTA;
    logic                 taOe;
    pciBus_t              pci;
    logic [dataWidth-1:0] adIn;
    logic [dataWidth-1:0] adOut;
    logic                 adOe;

    // Reference FIFO
    logic [dataWidth-1:0] fifoModel [$];
    logic                 modelOverflow = 1'b0;
    logic [31:0]          lfsrState;
    int                   errorCount = 0;
    int                   cycleCount = 0;

    `include "bridgeStim.svh"

    busBridge DUT (
        .BCLK, .nRESET, .cpu, .dIn, .dOut, .dOe, .nTA, .taOe,
        .pci, .adIn, .adOut, .adOe
    );

    initial BCLK = 1'b0;
    always #2 BCLK = ~BCLK;

    // Run limit from the table length
    always @(posedge BCLK) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= numSteps * 64) begin
            $display("Timeout: run did not finish within %0d cycles", numSteps * 64);
            $display("Regression failed");
            $fatal(1, "Run stopped by timeout");
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic stopOnMismatch(input string msg);
        errorCount++;
        $display("Mismatch at %0t ns: %s", $time, msg);
        $display("Regression failed");
        $fatal(1, "Stopped at first error");
    endtask

    // Bus protocol or model violation
    task automatic reportFailure(input string msg);
        errorCount++;
        $display("Error at %0t ns: %s", $time, msg);
        $display("Regression failed");
        $fatal(1, "Stopped at first error");
    endtask

    // Galois form, taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] state);
        logic [31:0] next;
        next = state >> 1;
        if (state[0]) begin
            next = next ^ 32'h8020_0003;
        end
        return next;
    endfunction

    // One step per data bit
    task automatic nextWord(output logic [dataWidth-1:0] word);
        word = '0;
        for (int i = 0; i < dataWidth; i++) begin
            word      = {word[dataWidth-2:0], lfsrState[0]};
            lfsrState = lfsrStep(lfsrState);
        end
    endtask

    // CPU owns the bus, no cycle running
    task automatic driveIdle();
        cpu      = '0;
        cpu.nTs  = 1'b1;
        cpu.nBen = 1'b1;
        cpu.rnw  = 1'b1;
        cpu.addr = 30'h100;
        pci      = '{pciCycle: 1'b0, nIrdy: 1'b1, nTrdy: 1'b1};
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // CPU data and register cycles
    ////////////////////////////////////////////////////////////////////////////

    task automatic runCpuCycle(input stimEntry_t step);
        logic [dataWidth-1:0] word;
        logic [dataWidth-1:0] expWord;
        statReg_t             stat;
        logic                 isRead;
        logic                 isReg;
        logic                 beatSeen;
        logic                 pciPending;
        int                   beatsDone;
        int                   idle;

        isRead     = (step.op == cpuRead) || (step.op == regRead);
        isReg      = (step.op == regWrite) || (step.op == regRead);
        pciPending = 1'b0;
        beatsDone  = 0;
        idle       = 0;
        nextWord(word);

        // Transfer start, sampled on the next edge
        @(posedge BCLK);
        #0.5;
        cpu.nTs  = 1'b0;
        cpu.nBg  = 1'b0;
        cpu.rnw  = isRead;
        cpu.tt0  = step.burst;
        cpu.tt1  = 1'b0;
        cpu.nBen = !isReg;
        cpu.addr = isReg ? 30'(regAddr) : 30'h100;
        dIn      = isReg ? 32'(step.ctrlVal) : word;
        @(posedge BCLK);
        #0.5;
        cpu.nTs = 1'b1;

        while (beatsDone < step.beats) begin
            @(negedge BCLK);
            beatSeen = !nTA;
            if (!nTA) begin
                assert (taOe === 1'b1 && dOe === isRead) else
                    stopOnMismatch($sformatf("beat with taOe %b dOe %b", taOe, dOe));
                if (isReg && isRead) begin
                    stat = dOut;
                    assert (stat.level === step.expLevel
                            && stat.level === fifoModel.size()
                            && stat.overflow === step.expOverflow
                            && stat.overflow === modelOverflow
                            && stat.pciDir === step.expDir
                            && stat.empty === (step.expLevel == 0)) else
                        stopOnMismatch($sformatf("status %h, expected level %0d ovf %b dir %b",
                            dOut, step.expLevel, step.expOverflow, step.expDir));
                end else if (isRead) begin
                    assert (fifoModel.size() > 0) else
                        reportFailure("read beat acknowledged on an empty FIFO");
                    expWord = fifoModel.pop_front();
                    assert (dOut === expWord) else
                        stopOnMismatch($sformatf("dOut %h, expected %h", dOut, expWord));
                end else if (!isReg) begin
                    assert (fifoModel.size() < fifoDepth) else
                        reportFailure("write beat acknowledged on a full FIFO");
                    fifoModel.push_back(dIn);
                end else begin
                    // Control write lands one cycle later, before the next check
                    if (step.ctrlVal[0]) begin
                        fifoModel.delete();
                    end
                    if (step.ctrlVal[2]) begin
                        modelOverflow = 1'b0;
                    end
                end
                beatsDone++;
                idle = 0;
            end else if (taOe) begin
                // Only a full write or an empty read may hold off nTA
                assert (!isReg && (isRead ? fifoModel.size() == 0
                                          : fifoModel.size() == fifoDepth)) else
                    reportFailure("nTA held high with room in the FIFO");
                idle++;
            end

            // PCI beat served under the stall goes into the model now
            if (pciPending) begin
                if (isRead) begin
                    fifoModel.push_back(adIn);
                end else begin
                    assert (adOe === 1'b1 && adOut === fifoModel[0]) else
                        stopOnMismatch($sformatf("adOut %h on stall pop, expected %h",
                            adOut, fifoModel[0]));
                    void'(fifoModel.pop_front());
                end
                pciPending = 1'b0;
            end

            @(posedge BCLK);
            #0.5;
            pci = '{pciCycle: 1'b0, nIrdy: 1'b1, nTrdy: 1'b1};
            if (idle == stallHold) begin
                // Direction follows the CPU cycle at the PCI cycle start
                idle = 0;
                pci  = '{pciCycle: 1'b1, nIrdy: 1'b0, nTrdy: 1'b0};
                if (isRead) begin
                    nextWord(adIn);
                end
                pciPending = 1'b1;
            end
            if (beatSeen && !isReg && !isRead) begin
                nextWord(word);
                dIn = word;
            end
        end

        driveIdle();
        // Trailing drive, then release
        @(negedge BCLK);
        assert (nTA === 1'b1 && taOe === 1'b1) else
            stopOnMismatch($sformatf("trailing cycle nTA %b taOe %b", nTA, taOe));
        @(negedge BCLK);
        assert (taOe === 1'b0 && dOe === 1'b0) else
            stopOnMismatch($sformatf("after cycle taOe %b dOe %b", taOe, dOe));
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // PCI data cycles
    ////////////////////////////////////////////////////////////////////////////

    task automatic runPciCycle(input stimEntry_t step);
        logic [dataWidth-1:0] expWord;
        logic                 isWrite;

        isWrite = (step.op == pciWrite);
        // Grant away, rnw low means data flows toward the CPU
        @(posedge BCLK);
        #0.5;
        cpu.nBg = 1'b1;
        cpu.rnw = !isWrite;
        pci     = '{pciCycle: 1'b1, nIrdy: 1'b1, nTrdy: 1'b1};
        @(negedge BCLK);
        assert (adOe === !isWrite) else
            stopOnMismatch($sformatf("adOe %b at PCI cycle start", adOe));

        for (int i = 0; i < step.beats; i++) begin
            @(posedge BCLK);
            #0.5;
            pci.nIrdy = 1'b0;
            pci.nTrdy = 1'b0;
            if (isWrite) begin
                nextWord(adIn);
            end
            @(negedge BCLK);
            assert (adOe === !isWrite) else
                stopOnMismatch($sformatf("adOe %b on PCI beat", adOe));
            if (isWrite) begin
                // Full FIFO drops the word and flags it
                if (fifoModel.size() < fifoDepth) begin
                    fifoModel.push_back(adIn);
                end else begin
                    modelOverflow = 1'b1;
                end
            end else begin
                assert (fifoModel.size() > 0) else
                    reportFailure("PCI read beat planned on an empty FIFO");
                expWord = fifoModel.pop_front();
                assert (adOut === expWord) else
                    stopOnMismatch($sformatf("adOut %h, expected %h", adOut, expWord));
            end
        end

        @(posedge BCLK);
        #0.5;
        driveIdle();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        nRESET    = 1'b0;
        dIn       = '0;
        adIn      = '0;
        lfsrState = 32'd41;
        driveIdle();
        repeat (4) @(posedge BCLK);
        #0.5;
        nRESET = 1'b1;

        @(negedge BCLK);
        assert (nTA === 1'b1 && taOe === 1'b0 && dOe === 1'b0 && adOe === 1'b0) else
            stopOnMismatch($sformatf("after reset nTA %b taOe %b dOe %b adOe %b",
                nTA, taOe, dOe, adOe));

        for (int s = 0; s < numSteps; s++) begin
            case (stimTable[s].op)
                pciWrite, pciRead: runPciCycle(stimTable[s]);
                default:           runCpuCycle(stimTable[s]);
            endcase
        end

        if (errorCount == 0) begin
            $display("Regression passed");
            $finish;
        end else begin
            $display("Regression failed");
            $fatal(1, "Errors found in the run");
        end
    end

endmodule

// ==== transferAck/taGenerator.sv ====
/*
 * Transfer acknowledge generator
 * Latches the MC68040 transfer start, counts single or burst beats and
 * drives nTA with a trailing cycle of drive before release
 */
`timescale 1ns/1ps

module taGenerator (
    input  logic                BCLK,
    input  logic                nRESET,
    input  bridgePkg::cpuBus_t  cpu,
    input  logic                regCycle,
    input  bridgePkg::ctrlReg_t ctrl,
    input  logic                full,
    input  logic                empty,
    output logic                nTA,
    output logic                taOe,
    output logic                cpuPush,
    output logic                cpuPop,
    output logic                regWr,
    output logic                regRd,
    output logic                dOe
);
    import bridgePkg::*;

    // Idle, start latched, beats running, trailing drive
    typedef enum logic [1:0] {
        sIdle,
        sStart,
        sActive,
        sTrail
    } taState_t;

    taState_t             state;
    logic [beatWidth-1:0] beatCount;
    logic [beatWidth-1:0] lastBeat;
    logic                 cycleRead;
    logic                 cycleReg;
    logic                 burstCycle;
    logic                 beatGo;
    logic                 beat;

    // Burst decode only counts when bursts are enabled
    assign burstCycle = cpu.tt0 && !cpu.tt1 && ctrl.burstEnable;

    ////////////////////////////////////////////////////////////////////////////
    // Cycle FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge BCLK or negedge nRESET) begin
        if (!nRESET) begin
            state     <= sIdle;
            beatCount <= '0;
            lastBeat  <= '0;
            cycleRead <= 1'b0;
            cycleReg  <= 1'b0;
        end else begin
            case (state)
                sIdle: begin
                    // Start only counts while this master holds the bus
                    if (!cpu.nTs && !cpu.nBg) begin
                        state     <= sStart;
                        cycleRead <= cpu.rnw;
                        cycleReg  <= regCycle;
                        beatCount <= '0;
                        // Register access is always a single beat
                        if (burstCycle && !regCycle) begin
                            lastBeat <= beatWidth'(burstBeats - 1);
                        end else begin
                            lastBeat <= '0;
                        end
                    end
                end
                sStart: begin
                    state <= sActive;
                end
                sActive: begin
                    if (beat) begin
                        if (beatCount == lastBeat) begin
                            state <= sTrail;
                        end else begin
                            beatCount <= beatCount + 1'b1;
                        end
                    end
                end
                // One cycle of nTA high keeps a stray ack off the next cycle
                sTrail: begin
                    state <= sIdle;
                end
                default: begin
                    state <= sIdle;
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Beat qualification and strobes
    ////////////////////////////////////////////////////////////////////////////

    // Writes wait on full, reads wait on empty, registers never wait
    assign beatGo = cycleReg || (cycleRead ? !empty : !full);
    assign beat   = (state == sActive) && beatGo;

    assign nTA  = !beat;
    assign taOe = (state == sActive) || (state == sTrail);

    // FIFO strobes line up with nTA low
    assign cpuPush = beat && !cycleReg && !cycleRead;
    assign cpuPop  = beat && !cycleReg && cycleRead;
    assign regWr   = beat && cycleReg && !cycleRead;
    assign regRd   = beat && cycleReg && cycleRead;
    // CPU data bus driven only on read beats
    assign dOe     = beat && cycleRead;

    // One FIFO strobe per beat
    aPushPop: assert property (@(posedge BCLK) disable iff (!nRESET)
        !(cpuPush && cpuPop));

    // Ack is driven, and drive holds through the following cycle
    aTaDrive: assert property (@(posedge BCLK) disable iff (!nRESET)
        !nTA |-> taOe ##1 taOe);

endmodule
